// File: ioss.f
src/ioss_pkg.sv
src/apb_reg_bridge.sv
src/irq_controller.sv
src/tick_counter.sv
src/periodic_timer.sv
src/gpio_port.sv
src/ioss_top.sv
testbench/tb_ioss.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I/O subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ioss -f ioss.f -o tb_ioss_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ioss_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

// File: src/apb_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module apb_reg_bridge #(
  parameter int PORT_WIDTH = 16
) (
  input  logic                                clk,
  input  logic                                resetq,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [ioss_pkg::ADDR_WIDTH-1:0]     paddr,
  input  logic [ioss_pkg::DATA_WIDTH-1:0]     pwdata,
  input  logic [ioss_pkg::IRQ_COUNT-1:0]      int_flags,
  input  logic [ioss_pkg::IRQ_COUNT-1:0]      int_mask,
  input  logic [ioss_pkg::TICK_WIDTH-1:0]     ticks_sampled,
  input  logic [PORT_WIDTH-1:0]               port_in,
  input  logic [PORT_WIDTH-1:0]               port_out,
  input  logic [PORT_WIDTH-1:0]               port_dir,
  output logic [ioss_pkg::DATA_WIDTH-1:0]     prdata,
  output logic                                pslverr,
  output logic [ioss_pkg::DATA_WIDTH-1:0]     wdata,
  output logic                                flags_wr,
  output logic                                mask_wr,
  output logic                                sample_wr,
  output logic                                reload_lo_wr,
  output logic                                reload_hi_wr,
  output logic                                out_wr,
  output logic                                dir_wr
);

  logic setup_q;
  logic access;
  logic wr_en;
  logic mapped;

  // Remember a setup phase so that only a proper access phase counts
  always_ff @(posedge clk)
  begin
    if (!resetq)
      setup_q <= 1'b0;
    else
      setup_q <= psel & ~penable;
  end

  assign access = psel & penable & setup_q;
  assign wr_en = access & pwrite;

  // One-hot write strobes, each lasting the single access cycle
  assign flags_wr = wr_en & (paddr == ioss_pkg::ADDR_INT_FLAGS);
  assign mask_wr = wr_en & (paddr == ioss_pkg::ADDR_INT_MASK);
  assign sample_wr = wr_en & (paddr == ioss_pkg::ADDR_TICKS_SAMPLE);
  assign reload_lo_wr = wr_en & (paddr == ioss_pkg::ADDR_TIMER_LO);
  assign reload_hi_wr = wr_en & (paddr == ioss_pkg::ADDR_TIMER_HI);
  assign out_wr = wr_en & (paddr == ioss_pkg::ADDR_PORT_OUT);
  assign dir_wr = wr_en & (paddr == ioss_pkg::ADDR_PORT_DIR);

  assign wdata = pwdata;

  // Read multiplexer, narrow registers are zero-extended
  always_comb
  begin
    prdata = '0;
    mapped = 1'b1;
    case (paddr)
      ioss_pkg::ADDR_INT_FLAGS:
        prdata[ioss_pkg::IRQ_COUNT-1:0] = int_flags;
      ioss_pkg::ADDR_INT_MASK:
        prdata[ioss_pkg::IRQ_COUNT-1:0] = int_mask;
      ioss_pkg::ADDR_TICKSS_LO:
        prdata = ticks_sampled[15:0];
      ioss_pkg::ADDR_TICKSS_MID:
        prdata = ticks_sampled[31:16];
      ioss_pkg::ADDR_TICKSS_HI:
        prdata = ticks_sampled[47:32];
      ioss_pkg::ADDR_PORT_IN:
        prdata[PORT_WIDTH-1:0] = port_in;
      ioss_pkg::ADDR_PORT_OUT:
        prdata[PORT_WIDTH-1:0] = port_out;
      ioss_pkg::ADDR_PORT_DIR:
        prdata[PORT_WIDTH-1:0] = port_dir;
      // Write-only registers read as zero
      ioss_pkg::ADDR_TICKS_SAMPLE,
      ioss_pkg::ADDR_TIMER_LO,
      ioss_pkg::ADDR_TIMER_HI:
        prdata = '0;
      default:
        mapped = 1'b0;
    endcase
  end

  assign pslverr = access & ~mapped;

endmodule

`default_nettype wire

// File: src/gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
  parameter int PORT_WIDTH = 16
) (
  input  logic                                clk,
  input  logic                                resetq,
  input  logic [ioss_pkg::DATA_WIDTH-1:0]     wdata,
  input  logic                                out_wr,
  input  logic                                dir_wr,
  input  logic [PORT_WIDTH-1:0]               gpio_in,
  output logic [PORT_WIDTH-1:0]               port_in,
  output logic [PORT_WIDTH-1:0]               port_out,
  output logic [PORT_WIDTH-1:0]               port_dir,
  output logic [PORT_WIDTH-1:0]               gpio_out,
  output logic [PORT_WIDTH-1:0]               gpio_oe
);

  logic [PORT_WIDTH-1:0] in_meta;

  // Output value and direction, a 1 in port_dir drives the pin
  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      port_out <= '0;
      port_dir <= '0;
    end
    else
    begin
      if (out_wr)
        port_out <= wdata[PORT_WIDTH-1:0];
      if (dir_wr)
        port_dir <= wdata[PORT_WIDTH-1:0];
    end
  end

  // Two-flop synchronizer on the pin inputs
  always_ff @(posedge clk)
  begin
    in_meta <= gpio_in;
    port_in <= in_meta;
  end

  assign gpio_out = port_out;
  assign gpio_oe = port_dir;

endmodule

`default_nettype wire

// File: src/ioss_pkg.sv
`default_nettype none

package ioss_pkg;

  // Bus widths
  localparam int DATA_WIDTH = 16;
  localparam int ADDR_WIDTH = 16;

  // Interrupt controller registers
  localparam logic [ADDR_WIDTH-1:0] ADDR_INT_FLAGS = 16'd40;
  localparam logic [ADDR_WIDTH-1:0] ADDR_INT_MASK = 16'd50;

  // Tick counter sample, written to capture and read back in three words
  localparam logic [ADDR_WIDTH-1:0] ADDR_TICKSS_LO = 16'd105;
  localparam logic [ADDR_WIDTH-1:0] ADDR_TICKSS_MID = 16'd106;
  localparam logic [ADDR_WIDTH-1:0] ADDR_TICKSS_HI = 16'd107;
  localparam logic [ADDR_WIDTH-1:0] ADDR_TICKS_SAMPLE = 16'd109;

  // Timer reload words, HI write restarts the count
  localparam logic [ADDR_WIDTH-1:0] ADDR_TIMER_LO = 16'd110;
  localparam logic [ADDR_WIDTH-1:0] ADDR_TIMER_HI = 16'd111;

  // General-purpose port
  localparam logic [ADDR_WIDTH-1:0] ADDR_PORT_IN = 16'd310;
  localparam logic [ADDR_WIDTH-1:0] ADDR_PORT_OUT = 16'd311;
  localparam logic [ADDR_WIDTH-1:0] ADDR_PORT_DIR = 16'd312;

  // Counter widths
  localparam int TICK_WIDTH = 48;
  localparam int TIMER_WIDTH = 32;

  // Interrupt layout
  localparam int IRQ_COUNT = 8;
  localparam int TIMER_IRQ = 7;

  // Flops in each external input synchronizer
  localparam int SYNC_STAGES = 3;

endpackage

`default_nettype wire

// File: src/ioss_top.sv
`timescale 1ns/1ps
`default_nettype none

module ioss_top #(
  parameter int NUM_EXT_IRQ = 4,
  parameter int PORT_WIDTH = 16
) (
  input  logic                                clk,
  input  logic                                resetq,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [ioss_pkg::ADDR_WIDTH-1:0]     paddr,
  input  logic [ioss_pkg::DATA_WIDTH-1:0]     pwdata,
  output logic [ioss_pkg::DATA_WIDTH-1:0]     prdata,
  output logic                                pslverr,
  input  logic [NUM_EXT_IRQ-1:0]              irq_in,
  input  logic [PORT_WIDTH-1:0]               gpio_in,
  output logic [ioss_pkg::IRQ_COUNT-1:0]      int_rqst,
  output logic [PORT_WIDTH-1:0]               gpio_out,
  output logic [PORT_WIDTH-1:0]               gpio_oe
);

  logic [ioss_pkg::DATA_WIDTH-1:0] wdata;
  logic flags_wr;
  logic mask_wr;
  logic sample_wr;
  logic reload_lo_wr;
  logic reload_hi_wr;
  logic out_wr;
  logic dir_wr;
  logic [ioss_pkg::IRQ_COUNT-1:0] int_flags;
  logic [ioss_pkg::IRQ_COUNT-1:0] int_mask;
  logic [ioss_pkg::TICK_WIDTH-1:0] ticks_sampled;
  logic [PORT_WIDTH-1:0] port_in;
  logic [PORT_WIDTH-1:0] port_out;
  logic [PORT_WIDTH-1:0] port_dir;
  logic expire;
  logic timer_pending;

  apb_reg_bridge #(
    .PORT_WIDTH (PORT_WIDTH)
  ) u_apb_reg_bridge (
    .clk           (clk),
    .resetq        (resetq),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .int_flags     (int_flags),
    .int_mask      (int_mask),
    .ticks_sampled (ticks_sampled),
    .port_in       (port_in),
    .port_out      (port_out),
    .port_dir      (port_dir),
    .prdata        (prdata),
    .pslverr       (pslverr),
    .wdata         (wdata),
    .flags_wr      (flags_wr),
    .mask_wr       (mask_wr),
    .sample_wr     (sample_wr),
    .reload_lo_wr  (reload_lo_wr),
    .reload_hi_wr  (reload_hi_wr),
    .out_wr        (out_wr),
    .dir_wr        (dir_wr)
  );

  irq_controller #(
    .NUM_EXT_IRQ (NUM_EXT_IRQ)
  ) u_irq_controller (
    .clk           (clk),
    .resetq        (resetq),
    .irq_in        (irq_in),
    .wdata         (wdata),
    .flags_wr      (flags_wr),
    .mask_wr       (mask_wr),
    .expire        (expire),
    .int_flags     (int_flags),
    .int_mask      (int_mask),
    .timer_pending (timer_pending),
    .int_rqst      (int_rqst)
  );

  tick_counter u_tick_counter (
    .clk           (clk),
    .resetq        (resetq),
    .sample_wr     (sample_wr),
    .ticks_sampled (ticks_sampled)
  );

  periodic_timer u_periodic_timer (
    .clk           (clk),
    .resetq        (resetq),
    .wdata         (wdata),
    .reload_lo_wr  (reload_lo_wr),
    .reload_hi_wr  (reload_hi_wr),
    .timer_pending (timer_pending),
    .expire        (expire)
  );

  gpio_port #(
    .PORT_WIDTH (PORT_WIDTH)
  ) u_gpio_port (
    .clk      (clk),
    .resetq   (resetq),
    .wdata    (wdata),
    .out_wr   (out_wr),
    .dir_wr   (dir_wr),
    .gpio_in  (gpio_in),
    .port_in  (port_in),
    .port_out (port_out),
    .port_dir (port_dir),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

endmodule

`default_nettype wire

// File: src/irq_controller.sv
`timescale 1ns/1ps
`default_nettype none

module irq_controller #(
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                                clk,
  input  logic                                resetq,
  input  logic [NUM_EXT_IRQ-1:0]              irq_in,
  input  logic [ioss_pkg::DATA_WIDTH-1:0]     wdata,
  input  logic                                flags_wr,
  input  logic                                mask_wr,
  input  logic                                expire,
  output logic [ioss_pkg::IRQ_COUNT-1:0]      int_flags,
  output logic [ioss_pkg::IRQ_COUNT-1:0]      int_mask,
  output logic                                timer_pending,
  output logic [ioss_pkg::IRQ_COUNT-1:0]      int_rqst
);

  // Synchronizer stages plus one history flop for the edge detector
  logic [NUM_EXT_IRQ-1:0] sync_q [ioss_pkg::SYNC_STAGES+1];
  logic [NUM_EXT_IRQ-1:0] ext_rise;
  logic [ioss_pkg::IRQ_COUNT-1:0] set_vec;
  logic [ioss_pkg::IRQ_COUNT-1:0] pending;

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      for (int k = 0; k <= ioss_pkg::SYNC_STAGES; k++)
        sync_q[k] <= '0;
    end
    else
    begin
      sync_q[0] <= irq_in;
      for (int k = 1; k <= ioss_pkg::SYNC_STAGES; k++)
        sync_q[k] <= sync_q[k-1];
    end
  end

  // Rising edge once the input has passed all synchronizer stages
  assign ext_rise = sync_q[ioss_pkg::SYNC_STAGES-1] & ~sync_q[ioss_pkg::SYNC_STAGES];

  // Bits between the external inputs and the timer bit are never set
  always_comb
  begin
    set_vec = '0;
    set_vec[NUM_EXT_IRQ-1:0] = ext_rise;
    set_vec[ioss_pkg::TIMER_IRQ] = expire;
  end

  // A set wins, otherwise a zero flag keeps the bit cleared
  always_ff @(posedge clk)
  begin
    if (!resetq)
      pending <= '0;
    else
      pending <= set_vec | (pending & int_flags);
  end

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      int_flags <= '1;
      int_mask <= '0;
    end
    else
    begin
      if (flags_wr)
        int_flags <= wdata[ioss_pkg::IRQ_COUNT-1:0];
      if (mask_wr)
        int_mask <= wdata[ioss_pkg::IRQ_COUNT-1:0];
    end
  end

  assign timer_pending = pending[ioss_pkg::TIMER_IRQ];
  assign int_rqst = pending & int_mask;

endmodule

`default_nettype wire

// File: src/periodic_timer.sv
`timescale 1ns/1ps
`default_nettype none

module periodic_timer (
  input  logic                                clk,
  input  logic                                resetq,
  input  logic [ioss_pkg::DATA_WIDTH-1:0]     wdata,
  input  logic                                reload_lo_wr,
  input  logic                                reload_hi_wr,
  input  logic                                timer_pending,
  output logic                                expire
);

  logic [ioss_pkg::DATA_WIDTH-1:0] reload_lo;
  logic [ioss_pkg::DATA_WIDTH-1:0] reload_hi;
  logic [ioss_pkg::TIMER_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      reload_lo <= '0;
      reload_hi <= '0;
    end
    else
    begin
      if (reload_lo_wr)
        reload_lo <= wdata;
      if (reload_hi_wr)
        reload_hi <= wdata;
    end
  end

  // HI write restarts with the new high word and the stored low word.
  // The count is held at the reload value while the interrupt is pending.
  always_ff @(posedge clk)
  begin
    if (!resetq)
      count <= '0;
    else if (reload_hi_wr)
      count <= {wdata, reload_lo};
    else if (timer_pending)
      count <= {reload_hi, reload_lo};
    else
      count <= count - 1'b1;
  end

  // High for the last cycle before the count would reach zero
  assign expire = (count == {{(ioss_pkg::TIMER_WIDTH-1){1'b0}}, 1'b1});

endmodule

`default_nettype wire

// File: src/tick_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tick_counter (
  input  logic                                clk,
  input  logic                                resetq,
  input  logic                                sample_wr,
  output logic [ioss_pkg::TICK_WIDTH-1:0]     ticks_sampled
);

  logic [ioss_pkg::TICK_WIDTH-1:0] ticks;

  // Free-running count of clock cycles since reset
  always_ff @(posedge clk)
  begin
    if (!resetq)
      ticks <= '0;
    else
      ticks <= ticks + 1'b1;
  end

  // Capture the count as it stands at the write edge
  always_ff @(posedge clk)
  begin
    if (!resetq)
      ticks_sampled <= '0;
    else if (sample_wr)
      ticks_sampled <= ticks;
  end

endmodule

`default_nettype wire

// File: testbench/tb_ioss.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ioss;

  localparam int NUM_EXT_IRQ = 4;
  localparam int PORT_WIDTH = 16;
  // Run length is dominated by the wait across the tick counter word boundary
  localparam int RESET_CYCLES = 10;
  localparam int BOUNDARY_CYCLES = 65536;
  localparam int OTHER_CYCLES = 800;
  localparam int MARGIN_CYCLES = 1000;
  localparam int RUN_CYCLES = RESET_CYCLES + BOUNDARY_CYCLES + OTHER_CYCLES + MARGIN_CYCLES;

  logic clk;
  logic resetq;
  logic psel;
  logic penable;
  logic pwrite;
  logic [ioss_pkg::ADDR_WIDTH-1:0] paddr;
  logic [ioss_pkg::DATA_WIDTH-1:0] pwdata;
  logic [ioss_pkg::DATA_WIDTH-1:0] prdata;
  logic pslverr;
  logic [NUM_EXT_IRQ-1:0] irq_in;
  logic [PORT_WIDTH-1:0] gpio_in;
  logic [ioss_pkg::IRQ_COUNT-1:0] int_rqst;
  logic [PORT_WIDTH-1:0] gpio_out;
  logic [PORT_WIDTH-1:0] gpio_oe;
  int errors;
  int checks;
  int cycles;
  int write_edge;
  integer seed;

  ioss_top #(
    .NUM_EXT_IRQ (NUM_EXT_IRQ),
    .PORT_WIDTH  (PORT_WIDTH)
  ) u_ioss_top (
    .clk      (clk),
    .resetq   (resetq),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pslverr  (pslverr),
    .irq_in   (irq_in),
    .gpio_in  (gpio_in),
    .int_rqst (int_rqst),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Edge count for timing samples and interrupts
  always @(posedge clk)
    cycles <= cycles + 1;

  // Port pins change only at the edge that ends a write access
  assert property (@(posedge clk) disable iff (!resetq)
    !$past(psel && penable && pwrite) |-> $stable(gpio_out) && $stable(gpio_oe))
  else
  begin
    errors++;
    $display("Fail %0t: port pins changed without a write", $time);
  end

  initial
  begin
    #(10 * RUN_CYCLES);
    $display("Timeout: run exceeded %0d cycles", RUN_CYCLES);
    $display("Verification failed");
    $finish;
  end

  task automatic check_value(input string what, input logic [47:0] got, input logic [47:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Called 1 ns after a rising edge and returns 1 ns after the nth edge that follows
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [15:0] data);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    wait_cycles(1);
    penable = 1'b1;
    wait_cycles(1);
    write_edge = cycles;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [15:0] data, output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    wait_cycles(1);
    penable = 1'b1;
    #4;
    data = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_read(input logic [15:0] addr, input logic [15:0] exp, input string what);
    logic [15:0] data;
    logic err;
    apb_read(addr, data, err);
    check_value(what, data, exp);
    check_value({what, " pslverr"}, err, 0);
  endtask

  task automatic sample_ticks(output logic [47:0] value, output int edge_cycle);
    logic [15:0] word;
    logic err;
    apb_write(ioss_pkg::ADDR_TICKS_SAMPLE, 16'h0);
    edge_cycle = write_edge;
    apb_read(ioss_pkg::ADDR_TICKSS_LO, word, err);
    value[15:0] = word;
    apb_read(ioss_pkg::ADDR_TICKSS_MID, word, err);
    value[31:16] = word;
    apb_read(ioss_pkg::ADDR_TICKSS_HI, word, err);
    value[47:32] = word;
  endtask

  initial
  begin
    logic [15:0] rd;
    logic err;
    logic [15:0] v;
    logic [47:0] ta;
    logic [47:0] tb;
    logic [47:0] tc;
    int ea;
    int eb;
    int ec;
    int r;
    errors = 0;
    checks = 0;
    cycles = 0;
    seed = 32'hd7cd6152;
    resetq = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    irq_in = '0;
    gpio_in = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    resetq = 1'b1;

    // Reset values
    expect_read(ioss_pkg::ADDR_INT_MASK, 16'h0000, "INT_MASK after reset");
    expect_read(ioss_pkg::ADDR_INT_FLAGS, 16'h00ff, "INT_FLAGS after reset");
    expect_read(ioss_pkg::ADDR_PORT_IN, 16'h0000, "PORT_IN after reset");
    expect_read(ioss_pkg::ADDR_PORT_OUT, 16'h0000, "PORT_OUT after reset");
    expect_read(ioss_pkg::ADDR_PORT_DIR, 16'h0000, "PORT_DIR after reset");
    expect_read(ioss_pkg::ADDR_TICKSS_LO, 16'h0000, "TICKSS_LO after reset");
    expect_read(ioss_pkg::ADDR_TICKSS_MID, 16'h0000, "TICKSS_MID after reset");
    expect_read(ioss_pkg::ADDR_TICKSS_HI, 16'h0000, "TICKSS_HI after reset");
    check_value("gpio_oe after reset", gpio_oe, 0);
    check_value("int_rqst after reset", int_rqst, 0);

    // Port registers, input synchronizer and unmapped access
    v = 16'($random(seed));
    apb_write(ioss_pkg::ADDR_PORT_OUT, v);
    check_value("gpio_out", gpio_out, v);
    expect_read(ioss_pkg::ADDR_PORT_OUT, v, "PORT_OUT readback");
    v = 16'($random(seed));
    apb_write(ioss_pkg::ADDR_PORT_DIR, v);
    check_value("gpio_oe", gpio_oe, v);
    expect_read(ioss_pkg::ADDR_PORT_DIR, v, "PORT_DIR readback");
    gpio_in = 16'($random(seed));
    wait_cycles(2);
    expect_read(ioss_pkg::ADDR_PORT_IN, gpio_in, "PORT_IN");
    expect_read(ioss_pkg::ADDR_TIMER_HI, 16'h0000, "write-only TIMER_HI");
    apb_read(16'd999, rd, err);
    check_value("unmapped prdata", rd, 0);
    check_value("unmapped pslverr", err, 1);

    // Tick sample pairs
    // The second pair straddles the middle word boundary
    sample_ticks(ta, ea);
    wait_cycles(20 + ($random(seed) & 15));
    sample_ticks(tb, eb);
    check_value("tick delta", tb - ta, 48'(eb - ea));
    wait_cycles(BOUNDARY_CYCLES - int'(tb[15:0]) + 5);
    sample_ticks(tc, ec);
    check_value("tick delta across boundary", tc - tb, 48'(ec - eb));
    check_value("tick middle word", tc[31:16], tb[31:16] + 16'd1);

    // External interrupts with the mask clear at first
    irq_in[0] = 1'b1;
    wait_cycles(5);
    check_value("masked int_rqst", int_rqst, 0);
    apb_write(ioss_pkg::ADDR_INT_MASK, 16'h000f);
    check_value("int_rqst after mask set", int_rqst[0], 1);
    for (int i = 1; i < NUM_EXT_IRQ; i++)
    begin
      irq_in[i] = 1'b1;
      wait_cycles(3);
      check_value("int_rqst before sync delay", int_rqst[i], 0);
      wait_cycles(1);
      check_value("int_rqst after sync delay", int_rqst[i], 1);
    end
    apb_write(ioss_pkg::ADDR_INT_FLAGS, 16'h00f0);
    wait_cycles(1);
    check_value("int_rqst after flag clear", int_rqst, 0);
    apb_write(ioss_pkg::ADDR_INT_FLAGS, 16'h00ff);
    wait_cycles(2);
    check_value("int_rqst after flag restore", int_rqst, 0);
    irq_in = '0;

    // Timer period before and after a clear and restore
    r = 8 + ($random(seed) & 63);
    apb_write(ioss_pkg::ADDR_INT_MASK, 16'h0080);
    apb_write(ioss_pkg::ADDR_TIMER_LO, r[15:0]);
    apb_write(ioss_pkg::ADDR_TIMER_HI, r[31:16]);
    wait_cycles(r - 1);
    check_value("timer request early", int_rqst[7], 0);
    wait_cycles(1);
    check_value("timer request", int_rqst[7], 1);
    apb_write(ioss_pkg::ADDR_INT_FLAGS, 16'h007f);
    apb_write(ioss_pkg::ADDR_INT_FLAGS, 16'h00ff);
    check_value("timer request after clear", int_rqst[7], 0);
    wait_cycles(r - 2);
    check_value("second timer request early", int_rqst[7], 0);
    wait_cycles(1);
    check_value("second timer request", int_rqst[7], 1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
